// ==== hdl/comp_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and register map of the compression unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package comp_pkg;

    typedef enum logic [1:0] {
        mode_rle      = 2'd0,
        mode_dict     = 2'd1,
        mode_short    = 2'd2,
        mode_scramble = 2'd3
    } comp_mode_e;

    // Bus block to encoder
    typedef struct packed {
        logic       clear;  // Drop done and overflow
        comp_mode_e mode;
        logic       start;  // One cycle
    } comp_cmd_t;

    // Encoder to bus block
    typedef struct packed {
        logic       busy;
        logic       done;
        logic       overflow;
        logic [5:0] out_len;  // 0 to 32
    } comp_status_t;

    typedef struct packed {
        logic       en;
        logic [4:0] addr;
        logic [7:0] data;
    } buf_wr_t;

    localparam logic [7:0] reg_ctrl    = 8'h00;  // Mode in 1:0, start in 7
    localparam logic [7:0] reg_status  = 8'h01;
    localparam logic [7:0] reg_in_len  = 8'h02;
    localparam logic [7:0] reg_out_len = 8'h03;
    localparam logic [7:0] reg_data_in = 8'h04;
    localparam logic [7:0] reg_clear   = 8'h05;
    localparam logic [7:0] out_base    = 8'h40;  // Output bytes at 0x40 to 0x5F

endpackage

// ==== hdl/comp_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte store for input and output blocks, registered write, async read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module comp_buffer
    import comp_pkg::*;
#(
    parameter int BUF_DEPTH = 32
) (
    input  logic       clk,
    input  buf_wr_t    wr,
    input  logic [4:0] rd_idx,
    output logic [7:0] rd_data
);

    // Contents only meaningful below the matching length
    logic [7:0] mem [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    assign rd_data = mem[rd_idx];

endmodule

// ==== hdl/lz_dictionary.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Literal dictionary for the LZ mode, parallel search, round-robin fill
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module lz_dictionary #(
    parameter int DICT_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          clear,
    input  logic [7:0]                    lookup,
    output logic                          hit,
    output logic [$clog2(DICT_DEPTH)-1:0] hit_idx,
    input  logic                          insert,
    input  logic [7:0]                    insert_byte
);

    localparam int IDX_W = $clog2(DICT_DEPTH);

    logic [7:0]            entry [DICT_DEPTH];
    logic [DICT_DEPTH-1:0] valid;
    logic [IDX_W-1:0]      wr_ptr;

    // Walk downwards so the lowest matching index wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = DICT_DEPTH - 1; i >= 0; i--) begin
            if (valid[i] && entry[i] == lookup) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid  <= '0;
            wr_ptr <= '0;
        end else if (clear) begin
            valid  <= '0;
            wr_ptr <= '0;
        end else if (insert) begin
            valid[wr_ptr] <= 1'b1;
            wr_ptr        <= (wr_ptr == IDX_W'(DICT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (insert && !clear) begin
            entry[wr_ptr] <= insert_byte;
        end
    end

endmodule

// ==== hdl/comp_encoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Block encoder, walks the input buffer and fills the output buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module comp_encoder
    import comp_pkg::*;
#(
    parameter int          BUF_DEPTH  = 32,
    parameter int          DICT_DEPTH = 16,
    parameter logic [55:0] PATTERN    = 56'h123456789ABCDE
) (
    input  logic                          clk,
    input  logic                          rst,
    input  comp_cmd_t                     cmd,
    input  logic [5:0]                    in_len,
    output logic [4:0]                    rd_idx,
    input  logic [7:0]                    rd_byte,
    output buf_wr_t                       out_wr,
    output logic                          dict_clear,
    output logic [7:0]                    dict_lookup,
    input  logic                          dict_hit,
    input  logic [$clog2(DICT_DEPTH)-1:0] dict_idx,
    output logic                          dict_insert,
    output logic [7:0]                    dict_byte,
    output comp_status_t                  status
);

    comp_mode_e  mode;
    logic        busy;
    logic        done;
    logic        overflow;
    logic [5:0]  rd_ptr;
    logic [5:0]  wr_ptr;
    logic        pend_valid;  // Second byte of a pair waits here
    logic [7:0]  pend_byte;
    logic        run_active;
    logic [7:0]  run_byte;
    logic [3:0]  run_len;
    logic [55:0] pattern;

    logic        start_ok;
    logic        at_end;
    logic        consume;
    logic        run_cont;
    logic        room;
    logic        rle_two;
    logic [7:0]  rle_first;
    logic        emit;
    logic        emit_two;
    logic [7:0]  byte0;
    logic [7:0]  byte1;

    assign start_ok = cmd.start && !busy;
    assign at_end   = (rd_ptr == in_len);
    assign consume  = busy && !pend_valid && !at_end;
    assign run_cont = run_active && rd_byte == run_byte && run_len != 4'd15;
    assign room     = wr_ptr < 6'(BUF_DEPTH);

    // A finished run is count then byte, or the byte alone
    assign rle_two   = run_len > 4'd1;
    assign rle_first = rle_two ? {4'h0, run_len} : run_byte;

    always_comb begin
        emit     = 1'b0;
        emit_two = 1'b0;
        byte0    = 8'h00;
        byte1    = 8'h00;
        if (busy) begin
            if (pend_valid) begin
                emit  = 1'b1;
                byte0 = pend_byte;
            end else if (!at_end) begin
                case (mode)
                    mode_rle: begin
                        if (run_active && !run_cont) begin  // Close previous run
                            emit     = 1'b1;
                            emit_two = rle_two;
                            byte0    = rle_first;
                            byte1    = run_byte;
                        end
                    end
                    mode_dict: begin
                        emit = 1'b1;
                        if (dict_hit) begin
                            emit_two = 1'b1;
                            byte0    = 8'(dict_idx);
                            byte1    = 8'h01;  // Match length is always one
                        end else begin
                            byte0 = rd_byte;
                        end
                    end
                    mode_short: begin
                        emit  = 1'b1;
                        byte0 = (rd_byte[7:4] == 4'h0) ? {4'h1, rd_byte[3:0]} : rd_byte;
                    end
                    default: begin
                        emit  = 1'b1;
                        byte0 = rd_byte ^ pattern[7:0];
                    end
                endcase
            end else if (run_active) begin
                // Flush the last run
                emit     = 1'b1;
                emit_two = rle_two;
                byte0    = rle_first;
                byte1    = run_byte;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode       <= mode_rle;
            busy       <= 1'b0;
            done       <= 1'b0;
            overflow   <= 1'b0;
            rd_ptr     <= 6'd0;
            wr_ptr     <= 6'd0;
            pend_valid <= 1'b0;
            run_active <= 1'b0;
            run_len    <= 4'd0;
            pattern    <= PATTERN;
        end else if (start_ok) begin
            mode       <= cmd.mode;
            busy       <= 1'b1;
            done       <= 1'b0;
            overflow   <= 1'b0;
            rd_ptr     <= 6'd0;
            wr_ptr     <= 6'd0;
            pend_valid <= 1'b0;
            run_active <= 1'b0;
            run_len    <= 4'd0;
            pattern    <= PATTERN;
        end else if (busy) begin
            if (emit) begin
                if (room) begin
                    wr_ptr <= wr_ptr + 6'd1;
                end else begin
                    overflow <= 1'b1;  // Byte dropped
                end
            end
            pend_valid <= emit_two;
            if (consume) begin
                rd_ptr <= rd_ptr + 6'd1;
                if (mode == mode_scramble) begin
                    pattern <= {pattern[54:0], pattern[55]};
                end
                if (mode == mode_rle) begin
                    run_active <= 1'b1;
                    run_len    <= run_cont ? run_len + 4'd1 : 4'd1;
                end
            end else if (!pend_valid && at_end) begin
                if (run_active) begin
                    run_active <= 1'b0;
                end else begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end else if (cmd.clear) begin
            done     <= 1'b0;
            overflow <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (emit_two) begin
            pend_byte <= byte1;
        end
        if (consume && mode == mode_rle && !run_cont) begin
            run_byte <= rd_byte;  // New run starts
        end
    end

    assign rd_idx      = rd_ptr[4:0];
    assign out_wr      = '{en: emit && room, addr: wr_ptr[4:0], data: byte0};
    assign dict_clear  = start_ok;
    assign dict_lookup = rd_byte;
    assign dict_insert = consume && mode == mode_dict && !dict_hit;
    assign dict_byte   = rd_byte;
    assign status      = '{busy: busy, done: done, overflow: overflow, out_len: wr_ptr};

endmodule

// ==== hdl/comp_wb_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic slave, register map and buffer access of the unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module comp_wb_regs
    import comp_pkg::*;
#(
    parameter int BUF_DEPTH = 32
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         cyc,
    input  logic         stb,
    input  logic         we,
    input  logic [7:0]   adr,
    input  logic [7:0]   dat_w,
    output logic [7:0]   dat_r,
    output logic         ack,
    output buf_wr_t      in_wr,
    output logic [5:0]   in_len,
    output logic [4:0]   out_idx,
    input  logic [7:0]   out_byte,
    output comp_cmd_t    cmd,
    input  comp_status_t status
);

    logic       access;  // First cycle of a bus access
    logic       wr_acc;
    logic       in_room;
    logic [7:0] rd_mux;
    comp_mode_e mode_q;
    logic       start_q;
    logic       clear_q;

    assign access  = cyc && stb && !ack;
    assign wr_acc  = access && we;
    assign in_room = in_len < 6'(BUF_DEPTH);
    assign out_idx = adr[4:0];

    // Input bytes land at the current length
    assign in_wr = '{en:   wr_acc && adr == reg_data_in && !status.busy && in_room,
                     addr: in_len[4:0],
                     data: dat_w};

    assign cmd = '{clear: clear_q, mode: mode_q, start: start_q};

    always_comb begin
        rd_mux = 8'h00;
        case (adr)
            reg_status:  rd_mux = {5'b0, status.overflow, status.done, status.busy};
            reg_in_len:  rd_mux = {2'b0, in_len};
            reg_out_len: rd_mux = {2'b0, status.out_len};
            default: begin
                if (adr[7:5] == out_base[7:5] && {1'b0, adr[4:0]} < status.out_len) begin
                    rd_mux = out_byte;
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack     <= 1'b0;
            dat_r   <= 8'h00;
            in_len  <= 6'd0;
            mode_q  <= mode_rle;
            start_q <= 1'b0;
            clear_q <= 1'b0;
        end else begin
            ack     <= access;
            start_q <= 1'b0;
            clear_q <= 1'b0;
            if (access && !we) begin
                dat_r <= rd_mux;
            end
            if (in_wr.en) begin
                in_len <= in_len + 6'd1;
            end
            if (wr_acc && !status.busy) begin  // Control writes ignored while running
                if (adr == reg_ctrl) begin
                    mode_q  <= comp_mode_e'(dat_w[1:0]);
                    start_q <= dat_w[7];
                end
                if (adr == reg_clear) begin
                    in_len  <= 6'd0;
                    clear_q <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== hdl/comp_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compression unit top level, Wishbone classic 8-bit slave
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module comp_unit
    import comp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  logic [7:0] adr,
    input  logic [7:0] dat_w,
    output logic [7:0] dat_r,
    output logic       ack
);

    localparam int          BUF_DEPTH  = 32;
    localparam int          DICT_DEPTH = 16;
    localparam logic [55:0] PATTERN    = 56'h123456789ABCDE;

    buf_wr_t      in_wr;
    buf_wr_t      out_wr;
    logic [5:0]   in_len;
    logic [4:0]   out_idx;
    logic [7:0]   out_byte;
    logic [4:0]   rd_idx;
    logic [7:0]   rd_byte;
    comp_cmd_t    cmd;
    comp_status_t status;

    logic                          dict_clear;
    logic [7:0]                    dict_lookup;
    logic                          dict_hit;
    logic [$clog2(DICT_DEPTH)-1:0] dict_idx;
    logic                          dict_insert;
    logic [7:0]                    dict_byte;

    comp_wb_regs #(.BUF_DEPTH(BUF_DEPTH)) regs (
        .clk, .rst, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
        .in_wr, .in_len, .out_idx, .out_byte, .cmd, .status
    );

    comp_buffer #(.BUF_DEPTH(BUF_DEPTH)) in_buf (
        .clk, .wr(in_wr), .rd_idx(rd_idx), .rd_data(rd_byte)
    );

    comp_buffer #(.BUF_DEPTH(BUF_DEPTH)) out_buf (
        .clk, .wr(out_wr), .rd_idx(out_idx), .rd_data(out_byte)
    );

    comp_encoder #(
        .BUF_DEPTH(BUF_DEPTH),
        .DICT_DEPTH(DICT_DEPTH),
        .PATTERN(PATTERN)
    ) encoder (
        .clk, .rst, .cmd, .in_len, .rd_idx, .rd_byte, .out_wr,
        .dict_clear, .dict_lookup, .dict_hit, .dict_idx, .dict_insert, .dict_byte,
        .status
    );

    lz_dictionary #(.DICT_DEPTH(DICT_DEPTH)) dict (
        .clk, .rst,
        .clear(dict_clear),
        .lookup(dict_lookup),
        .hit(dict_hit),
        .hit_idx(dict_idx),
        .insert(dict_insert),
        .insert_byte(dict_byte)
    );

endmodule

// ==== include/comp_model.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference encoder for the testbench, gives expected bytes and overflow
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef COMP_MODEL_SVH
`define COMP_MODEL_SVH

function automatic void comp_model(
    input  logic [7:0]           blk [32],
    input  int                   len,
    input  comp_pkg::comp_mode_e mode,
    output logic [7:0]           exp_bytes [32],
    output int                   exp_len,
    output bit                   exp_ovf
);
    logic [7:0]  dict [16];
    bit          dvalid [16];
    int          dptr;
    int          hit;
    int          run;
    int          i;
    logic [55:0] pat;
    logic [7:0]  emit [$];

    dptr = 0;
    pat  = 56'h123456789ABCDE;
    foreach (dvalid[k]) dvalid[k] = 0;
    i = 0;
    while (i < len) begin
        run = 1;
        case (mode)
            comp_pkg::mode_rle: begin
                while (i + run < len && blk[i + run] == blk[i] && run < 15) run++;
                if (run > 1) emit.push_back(8'(run));
                emit.push_back(blk[i]);
            end
            comp_pkg::mode_dict: begin
                hit = -1;
                for (int k = 15; k >= 0; k--) begin
                    if (dvalid[k] && dict[k] == blk[i]) hit = k;  // Lowest index wins
                end
                if (hit >= 0) begin
                    emit.push_back(8'(hit));
                    emit.push_back(8'h01);
                end else begin
                    emit.push_back(blk[i]);
                    dict[dptr]   = blk[i];
                    dvalid[dptr] = 1;
                    dptr         = (dptr + 1) % 16;
                end
            end
            comp_pkg::mode_short: begin
                emit.push_back((blk[i][7:4] == 4'h0) ? {4'h1, blk[i][3:0]} : blk[i]);
            end
            default: begin
                emit.push_back(blk[i] ^ pat[7:0]);
                pat = {pat[54:0], pat[55]};
            end
        endcase
        i += run;
    end

    exp_ovf = emit.size() > 32;
    exp_len = exp_ovf ? 32 : emit.size();
    foreach (exp_bytes[k]) exp_bytes[k] = (k < exp_len) ? emit[k] : 8'h00;
endfunction

`endif

// ==== sim/tb_comp_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the compression unit, drives the Wishbone port
// and compares every block with the reference encoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_comp_unit
    import comp_pkg::*;
();

    localparam int CYCLE_LIMIT = 6000;  // All runs with a wide margin

    logic       clk;
    logic       rst;
    logic       cyc;
    logic       stb;
    logic       we;
    logic [7:0] adr;
    logic [7:0] dat_w;
    logic [7:0] dat_r;
    logic       ack;

    int         seed;
    int         cycles;
    int         errors;
    int         checks;
    logic [7:0] cur_blk [32];  // Block under test
    int         cur_len;
    comp_mode_e cur_mode;
    string      cur_name;
    bit         cmp_req;       // Set by the sequence, cleared by the compare process

    `include "comp_model.svh"

    comp_unit dut (.clk, .rst, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not end within %0d clock cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // Wait for ack, then release the bus on the next edge
    task automatic finish_access(output logic [7:0] d);
        do begin
            @(negedge clk);
        end while (ack !== 1'b1);
        d = dat_r;  // Valid with ack
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] a, input logic [7:0] d);
        logic [7:0] unused;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= a;
        dat_w <= d;
        finish_access(unused);
    endtask

    task automatic wb_read(input logic [7:0] a, output logic [7:0] d);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= a;
        finish_access(d);
    endtask

    // Load, start, optionally poke the bus while busy, then hand over to compare
    task automatic run_block(input string name, input int len, input comp_mode_e mode,
                             input bit load, input bit poke);
        logic [7:0] v;
        cur_name = name;
        cur_len  = len;
        cur_mode = mode;
        if (load) begin
            wb_write(reg_clear, 8'h00);
            for (int i = 0; i < len; i++) begin
                wb_write(reg_data_in, cur_blk[i]);
            end
        end
        wb_write(reg_ctrl, {1'b1, 5'b0, mode});
        if (poke) begin
            wb_read(reg_status, v);
            checks++;
            if (v[0] !== 1'b1) begin
                errors++;
                $display("%s: unit not busy after start, busy-time writes not tested", name);
            end
            wb_write(reg_data_in, 8'hEE);
            wb_write(reg_ctrl, {1'b1, 5'b0, mode_short});
        end
        do begin
            wb_read(reg_status, v);
        end while (v[1] !== 1'b1);
        cmp_req = 1'b1;
        wait (!cmp_req);
    endtask

    always begin : compare
        logic [7:0] exp_bytes [32];
        int         exp_len;
        bit         exp_ovf;
        logic [7:0] v;
        wait (cmp_req);
        comp_model(cur_blk, cur_len, cur_mode, exp_bytes, exp_len, exp_ovf);
        wb_read(reg_out_len, v);
        checks++;
        if (v !== 8'(exp_len)) begin
            errors++;
            $display("FAIL %s out_len: expected %0d, actual %0d", cur_name, exp_len, v);
        end
        wb_read(reg_in_len, v);
        checks++;
        if (v !== 8'(cur_len)) begin
            errors++;
            $display("FAIL %s in_len: expected %0d, actual %0d", cur_name, cur_len, v);
        end
        wb_read(reg_status, v);
        checks++;
        if (v[2:0] !== {exp_ovf, 2'b10}) begin  // Overflow, done, not busy
            errors++;
            $display("FAIL %s status: expected %03b, actual %03b",
                     cur_name, {exp_ovf, 2'b10}, v[2:0]);
        end
        // Bytes past out_len must read as zero
        for (int n = 0; n < 32; n++) begin
            wb_read(out_base + 8'(n), v);
            checks++;
            if (v !== exp_bytes[n]) begin
                errors++;
                $display("FAIL %s byte %0d: expected %02h, actual %02h",
                         cur_name, n, exp_bytes[n], v);
            end
        end
        cmp_req = 1'b0;
    end

    initial begin
        logic [7:0]  v;
        logic [31:0] r;
        clk      = 1'b0;
        rst      = 1'b1;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = 8'h00;
        dat_w    = 8'h00;
        seed     = 95471;
        cycles   = 0;
        errors   = 0;
        checks   = 0;
        cmp_req  = 1'b0;
        cur_len  = 0;
        cur_mode = mode_rle;
        cur_name = "";
        foreach (cur_blk[i]) cur_blk[i] = 8'h00;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // Runs of 1, 2 and 15, then single bytes
        cur_blk[0] = 8'h11;
        for (int i = 1; i < 3; i++) cur_blk[i] = 8'h22;
        for (int i = 3; i < 18; i++) cur_blk[i] = 8'h33;
        for (int i = 18; i < 32; i++) cur_blk[i] = 8'(i);
        run_block("rle_short_runs", 32, mode_rle, 1'b1, 1'b0);
        for (int i = 0; i < 17; i++) cur_blk[i] = 8'h44;  // Splits into 15 and 2
        for (int i = 17; i < 32; i++) cur_blk[i] = 8'h55;
        run_block("rle_long_run", 32, mode_rle, 1'b1, 1'b0);

        // Ten literals, five repeats, five new literals
        for (int i = 0; i < 10; i++) cur_blk[i] = 8'(160 + i);
        cur_blk[10] = 8'hA3;
        cur_blk[11] = 8'hA0;
        cur_blk[12] = 8'hA9;
        cur_blk[13] = 8'hA3;
        cur_blk[14] = 8'hA5;
        for (int i = 15; i < 20; i++) cur_blk[i] = 8'(176 + i - 15);
        run_block("dict_repeats", 20, mode_dict, 1'b1, 1'b0);
        run_block("dict_restart", 20, mode_dict, 1'b0, 1'b0);

        for (int i = 0; i < 32; i++) begin
            r          = $random(seed);
            cur_blk[i] = r[8] ? {4'h0, r[3:0]} : r[7:0];
        end
        run_block("short_random", 32, mode_short, 1'b1, 1'b0);
        for (int i = 0; i < 32; i++) begin
            r          = $random(seed);
            cur_blk[i] = r[7:0];
        end
        run_block("scramble_random", 32, mode_scramble, 1'b1, 1'b0);
        run_block("scramble_reload", 32, mode_scramble, 1'b0, 1'b0);

        // Exactly full output buffers
        for (int i = 0; i < 32; i++) cur_blk[i] = 8'(i * 7 + 3);
        run_block("dict_distinct", 32, mode_dict, 1'b1, 1'b0);
        for (int i = 0; i < 32; i++) cur_blk[i] = (i % 2 == 1) ? 8'h5A : 8'hA5;
        run_block("rle_alternate", 32, mode_rle, 1'b1, 1'b0);

        // Sixteen literals then fifteen hits overflow, input buffer keeps one free slot
        for (int i = 0; i < 16; i++) cur_blk[i] = 8'(i * 11 + 1);
        for (int i = 16; i < 31; i++) cur_blk[i] = cur_blk[i - 16];
        run_block("dict_overflow", 31, mode_dict, 1'b1, 1'b1);

        cur_name = "clear";
        wb_write(reg_clear, 8'h00);
        wb_read(reg_in_len, v);
        checks++;
        if (v !== 8'h00) begin
            errors++;
            $display("FAIL %s in_len: expected %0d, actual %0d", cur_name, 0, v);
        end
        wb_read(reg_status, v);
        checks++;
        if (v[2:0] !== 3'b000) begin
            errors++;
            $display("FAIL %s status: expected %03b, actual %03b", cur_name, 3'b000, v[2:0]);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
hdl/comp_pkg.sv
hdl/comp_buffer.sv
hdl/lz_dictionary.sv
hdl/comp_encoder.sv
hdl/comp_wb_regs.sv
hdl/comp_unit.sv
sim/tb_comp_unit.sv

// ==== Makefile ====
# Verilator build and run of the compression unit testbench

VERILATOR ?= verilator
TOP       ?= tb_comp_unit
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) $(VFLAGS)

# Status follows the search for the pass message in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP) $(VFLAGS)

clean:
	rm -rf $(OBJ_DIR)
